/* sim.f */
common/cache_pkg.sv
cache/cache_decode.sv
cache/cache_way.sv
cache/cache_replace.sv
cache/cache_ctrl.sv
cache/cache_result.sv
verilog/dcache_top.sv
testbench/tb_clock.sv
testbench/tb_dcache.sv

/* Makefile */
TOP := tb_dcache
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_dcache.sv */
// ********************
// tb_dcache: data cache testbench with a line memory model, a shadow byte
// memory and a model of the used-bit replacement
// ********************
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import cache_pkg::*; ();

    localparam int NUM_WAYS        = 4;
    localparam int NUM_SETS        = 64;
    localparam int INDEX_BITS      = $clog2(NUM_SETS);
    localparam int TAG_BITS        = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int RANDOM_ACCESSES = 300;
    localparam int TIMEOUT_CYCLES  = 400 * 30;  // accesses times worst-case cycles

    logic                  clk;
    logic                  rst_n;
    logic [ADDR_BITS-1:0]  addr;
    logic [31:0]           wdata;
    access_size_e          size;
    logic                  read_en;
    logic                  write_en;
    logic                  busy;
    logic                  done;
    logic                  hit;
    logic [31:0]           rdata;
    logic                  mem_save;
    logic                  mem_load;
    logic [ADDR_BITS-1:0]  mem_addr;
    logic [LINE_BITS-1:0]  mem_wdata;
    logic                  mem_save_done;
    logic                  mem_load_done;
    logic [LINE_BITS-1:0]  mem_rdata;

    logic [7:0]            shadow [logic [31:0]];      // cpu view of every byte
    logic [LINE_BITS-1:0]  mem_lines [logic [31:0]];   // lines written back
    logic                  model_valid [NUM_SETS][NUM_WAYS];
    logic                  model_dirty [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0]   model_tag [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]   model_used [NUM_SETS];
    logic                  expect_save;
    logic [31:0]           expect_save_addr;
    logic [31:0]           expect_load_addr;
    logic                  last_hit;
    int                    last_latency;
    int                    last_saves;
    int                    last_loads;
    int                    save_total = 0;
    int                    load_total = 0;
    int                    cycle_count = 0;

    tb_clock tb_clock_i (.clk, .rst_n);

    dcache_top #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) dcache_top_i (
        .clk, .rst_n, .addr, .wdata, .size, .read_en, .write_en,
        .busy, .done, .hit, .rdata,
        .mem_save, .mem_load, .mem_addr, .mem_wdata,
        .mem_save_done, .mem_load_done, .mem_rdata
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // every byte of the address folded in
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    function automatic logic [LINE_BITS-1:0] shadow_line(input logic [31:0] base);
        logic [LINE_BITS-1:0] l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = shadow_byte(base + 32'(i));
        end
        return l;
    endfunction

    function automatic logic [LINE_BITS-1:0] memory_line(input logic [31:0] base);
        logic [LINE_BITS-1:0] l;
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = fill_byte(base + 32'(i));   // never-written line
        end
        return l;
    endfunction

    function automatic int size_bytes(input access_size_e sz);
        case (sz)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] a, input access_size_e sz);
        logic [31:0] v;
        v = {shadow_byte(a + 32'd3), shadow_byte(a + 32'd2), shadow_byte(a + 32'd1),
             shadow_byte(a)};
        case (sz)
            SIZE_BYTE: v = v & 32'h0000_00ff;
            SIZE_HALF: v = v & 32'h0000_ffff;
            default:   v = v;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] line_address(input int t, input int s);
        return 32'h0008_0000 | (32'(t) << (INDEX_BITS + OFFSET_BITS)) | (32'(s) << OFFSET_BITS);
    endfunction

    // used-bit rule: set the bit, a full set keeps only the touched way
    function automatic void model_touch(input logic [INDEX_BITS-1:0] s, input int w);
        logic [NUM_WAYS-1:0] nxt;
        nxt = model_used[s] | (NUM_WAYS'(1) << w);
        if (&nxt) begin
            nxt = NUM_WAYS'(1) << w;
        end
        model_used[s] = nxt;
    endfunction

    task automatic predict(input logic [31:0] a, input logic write, output logic exp_hit);
        logic [INDEX_BITS-1:0] s;
        logic [TAG_BITS-1:0]   t;
        int                    way;
        int                    victim;
        s           = a[OFFSET_BITS +: INDEX_BITS];
        t           = a[ADDR_BITS-1 -: TAG_BITS];
        exp_hit     = 1'b0;
        expect_save = 1'b0;
        way         = 0;
        victim      = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                exp_hit = 1'b1;
                way     = w;
            end
            if (victim < 0 && !model_used[s][w]) begin
                victim = w;     // lowest clear bit
            end
        end
        if (!exp_hit) begin
            expect_save      = model_valid[s][victim] && model_dirty[s][victim];
            expect_save_addr = {model_tag[s][victim], s, {OFFSET_BITS{1'b0}}};
            expect_load_addr = {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            model_valid[s][victim] = 1'b1;
            model_dirty[s][victim] = 1'b0;
            model_tag[s][victim]   = t;
            model_touch(s, victim);     // refill touches the victim
            way = victim;
        end
        model_touch(s, way);
        if (write) begin
            model_dirty[s][way] = 1'b1;
        end
    endtask

    task automatic run_access(input logic write, input logic [31:0] a, input access_size_e sz,
                              input logic [31:0] wd);
        logic exp_hit;
        int   saves_before;
        int   loads_before;
        predict(a, write, exp_hit);
        saves_before = save_total;
        loads_before = load_total;
        addr     = a;
        wdata    = wd;
        size     = sz;
        read_en  = !write;
        write_en = write;
        @(negedge clk);
        read_en      = 1'b0;
        write_en     = 1'b0;
        last_latency = 1;
        while (!done) begin
            @(negedge clk);
            last_latency++;
        end
        last_hit   = hit;
        last_saves = save_total - saves_before;
        last_loads = load_total - loads_before;
        assert (busy) else report_failure($sformatf("[ERROR] %0t: busy low during done", $time));
        assert (hit == exp_hit) else report_failure($sformatf(
            "[ERROR] %0t: hit %b at %h, expected %b", $time, hit, a, exp_hit));
        if (exp_hit) begin
            assert (last_latency == 1 && last_saves == 0 && last_loads == 0)
                else report_failure($sformatf("[ERROR] %0t: hit at %h took %0d cycles, %0d loads",
                                              $time, a, last_latency, last_loads));
        end else begin
            assert (last_loads == 1 && last_saves == (expect_save ? 1 : 0))
                else report_failure($sformatf("[ERROR] %0t: miss at %h saw %0d saves, %0d loads",
                                              $time, a, last_saves, last_loads));
        end
        if (!write) begin
            assert (rdata == expected_read(a, sz)) else report_failure($sformatf(
                "[ERROR] %0t: read %h gave %h, expected %h", $time, a, rdata,
                expected_read(a, sz)));
        end else begin
            for (int i = 0; i < size_bytes(sz); i++) begin
                shadow[a + 32'(i)] = wd[i*8 +: 8];
            end
        end
        @(negedge clk);
        assert (!done && !busy) else report_failure($sformatf(
            "[ERROR] %0t: done or busy still high after the access", $time));
    endtask

    task automatic random_access();
        int           pick;
        logic         write;
        logic [31:0]  a;
        access_size_e sz;
        pick  = $urandom_range(0, 2);
        sz    = (pick == 0) ? SIZE_BYTE : (pick == 1) ? SIZE_HALF : SIZE_WORD;
        write = ($urandom_range(0, 1) == 1);
        a     = line_address($urandom_range(0, 5), $urandom_range(0, 3));
        a     = a | 32'($urandom_range(0, 15));
        if (sz == SIZE_WORD) begin
            a = a & ~32'd3;     // aligned accesses only
        end else if (sz == SIZE_HALF) begin
            a = a & ~32'd1;
        end
        run_access(write, a, sz, $urandom());
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("simulation ran past %0d cycles without finishing",
                                     TIMEOUT_CYCLES));
        end
    end

    // line memory answering after 0 to 5 cycles
    initial begin : memory_model
        int delay;
        mem_save_done = 1'b0;
        mem_load_done = 1'b0;
        mem_rdata     = '0;
        forever begin
            @(negedge clk);
            mem_save_done = 1'b0;
            mem_load_done = 1'b0;
            assert (!(mem_save && mem_load)) else report_failure($sformatf(
                "[ERROR] %0t: mem_save and mem_load both high", $time));
            if (mem_save) begin
                save_total++;
                assert (expect_save) else report_failure($sformatf(
                    "[ERROR] %0t: write-back of a line that is not dirty", $time));
                assert (mem_addr == expect_save_addr) else report_failure($sformatf(
                    "[ERROR] %0t: save address %h, expected %h", $time, mem_addr,
                    expect_save_addr));
                assert (mem_wdata == shadow_line(mem_addr)) else report_failure($sformatf(
                    "[ERROR] %0t: saved line %h differs from shadow", $time, mem_wdata));
                mem_lines[mem_addr] = mem_wdata;
                delay = $urandom_range(0, 5);
                repeat (delay) @(negedge clk);
                mem_save_done = 1'b1;
            end else if (mem_load) begin
                load_total++;
                assert (mem_addr == expect_load_addr) else report_failure($sformatf(
                    "[ERROR] %0t: load address %h, expected %h", $time, mem_addr,
                    expect_load_addr));
                delay = $urandom_range(0, 5);
                repeat (delay) @(negedge clk);
                mem_rdata     = memory_line(mem_addr);
                mem_load_done = 1'b1;
            end
        end
    end

    initial begin : stimulus
        void'($urandom(37));
        addr      = '0;
        wdata     = '0;
        size      = SIZE_WORD;
        read_en   = 1'b0;
        write_en  = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_used[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        @(posedge rst_n);
        @(negedge clk);
        assert (!busy && !done && !mem_save && !mem_load) else report_failure($sformatf(
            "[ERROR] %0t: busy, done, mem_save or mem_load high after reset", $time));

        // stores of each size into one line, then reads back
        run_access(1'b1, 32'h0000_0100, SIZE_WORD, 32'hdead_beef);
        run_access(1'b1, 32'h0000_0106, SIZE_HALF, 32'h1234_5678);
        assert (last_hit && last_latency == 1 && last_loads == 0) else report_failure($sformatf(
            "[ERROR] %0t: second access to the same line did not hit", $time));
        run_access(1'b1, 32'h0000_010b, SIZE_BYTE, 32'h0000_00a5);
        run_access(1'b0, 32'h0000_0100, SIZE_WORD, '0);
        run_access(1'b0, 32'h0000_0104, SIZE_WORD, '0);
        run_access(1'b0, 32'h0000_0106, SIZE_HALF, '0);
        run_access(1'b0, 32'h0000_0108, SIZE_WORD, '0);
        run_access(1'b0, 32'h0000_010b, SIZE_BYTE, '0);
        run_access(1'b0, 32'h0000_0109, SIZE_BYTE, '0);

        // one line too many in a set, dirty victim first, then clean
        for (int t = 0; t <= NUM_WAYS; t++) begin
            run_access(1'b1, line_address(t, 5), SIZE_WORD, 32'(t) * 32'h0101_0101);
        end
        assert (last_saves == 1) else report_failure("dirty victim was not written back");
        for (int t = 0; t <= NUM_WAYS; t++) begin
            run_access(1'b0, line_address(t, 6), SIZE_WORD, '0);
        end
        assert (last_saves == 0 && last_loads == 1)
            else report_failure("clean victim did not go straight to refill");

        repeat (RANDOM_ACCESSES) random_access();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// ********************
// tb_clock: 100 ns clock and a reset held low for 5 cycles
// ********************
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);             // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
// ********************
// dcache_top: write-back set-associative data cache with refill control
// ********************
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 64
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [ADDR_BITS-1:0]     addr,
    input  wire [31:0]              wdata,
    input  wire access_size_e       size,
    input  wire                     read_en,
    input  wire                     write_en,
    output logic                    busy,
    output logic                    done,
    output logic                    hit,
    output logic [31:0]             rdata,
    output logic                    mem_save,
    output logic                    mem_load,
    output logic [ADDR_BITS-1:0]    mem_addr,
    output logic [LINE_BITS-1:0]    mem_wdata,
    input  wire                     mem_save_done,
    input  wire                     mem_load_done,
    input  wire [LINE_BITS-1:0]     mem_rdata
);

    localparam int WAY_BITS   = $clog2(NUM_WAYS);
    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    logic [TAG_BITS-1:0]            req_tag;
    logic [INDEX_BITS-1:0]          req_index;
    logic [OFFSET_BITS-1:0]         req_offset;
    access_size_e                   req_size;
    logic                           req_write;
    logic                           req_valid;
    logic [LINE_BYTES-1:0]          byte_mask;
    logic [LINE_BITS-1:0]           line_wdata;
    logic [NUM_WAYS-1:0]            way_hit;
    logic [NUM_WAYS-1:0]            way_dirty;
    logic [NUM_WAYS*TAG_BITS-1:0]   way_tag;
    logic [NUM_WAYS*LINE_BITS-1:0]  way_line;
    logic [NUM_WAYS-1:0]            way_store;
    logic [NUM_WAYS-1:0]            way_fill;
    logic [LINE_BITS-1:0]           fill_line;
    logic                           touch;
    logic [WAY_BITS-1:0]            touch_way;
    logic [WAY_BITS-1:0]            victim_way;

    cache_decode #(.NUM_SETS(NUM_SETS)) cache_decode_i (
        .clk, .rst_n, .addr, .wdata, .size, .read_en, .write_en, .busy,
        .req_tag, .req_index, .req_offset, .req_size, .req_write, .req_valid,
        .byte_mask, .line_wdata
    );

    cache_ctrl #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) cache_ctrl_i (
        .clk, .rst_n, .req_valid, .req_write, .req_index, .req_tag,
        .way_hit, .way_dirty, .way_tag, .way_line, .victim_way,
        .mem_save_done, .mem_load_done, .mem_rdata,
        .busy, .done, .hit, .way_store, .way_fill, .fill_line, .touch, .touch_way,
        .mem_save, .mem_load, .mem_addr, .mem_wdata
    );

    cache_replace #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) cache_replace_i (
        .clk, .rst_n, .req_index, .touch, .touch_way, .victim_way
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(.NUM_SETS(NUM_SETS)) cache_way_i (
            .clk,
            .rst_n,
            .req_index,
            .req_tag,
            .byte_mask,
            .line_wdata,
            .store     (way_store[w]),
            .fill      (way_fill[w]),
            .fill_line,
            .hit       (way_hit[w]),
            .dirty     (way_dirty[w]),
            .tag       (way_tag[w*TAG_BITS +: TAG_BITS]),
            .line      (way_line[w*LINE_BITS +: LINE_BITS])
        );
    end

    cache_result #(.NUM_WAYS(NUM_WAYS)) cache_result_i (
        .way_hit, .way_line, .req_offset, .req_size, .rdata
    );

endmodule

`default_nettype wire

/* cache/cache_result.sv */
// ********************
// cache_result: picks the hit line and aligns the load data
// ********************
`timescale 1ns/1ps
`default_nettype none

module cache_result
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  wire [NUM_WAYS-1:0]              way_hit,
    input  wire [NUM_WAYS*LINE_BITS-1:0]    way_line,
    input  wire [OFFSET_BITS-1:0]           req_offset,
    input  wire access_size_e               req_size,
    output logic [31:0]                     rdata
);

    logic [LINE_BITS-1:0] line_sel;
    logic [LINE_BITS-1:0] line_shift;

    // at most one way hits, so an or of the masked lines is enough
    always_comb begin
        line_sel = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                line_sel = line_sel | way_line[w*LINE_BITS +: LINE_BITS];
            end
        end
    end

    assign line_shift = line_sel >> {req_offset, 3'b000};

    always_comb begin
        case (req_size)
            SIZE_BYTE: rdata = {24'd0, line_shift[7:0]};    // zero-extended
            SIZE_HALF: rdata = {16'd0, line_shift[15:0]};
            default:   rdata = line_shift[31:0];
        endcase
    end

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
// ********************
// cache_ctrl: lookup, dirty write-back and refill state machine
// ********************
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 64,
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             req_valid,
    input  wire                             req_write,
    input  wire [INDEX_BITS-1:0]            req_index,
    input  wire [TAG_BITS-1:0]              req_tag,
    input  wire [NUM_WAYS-1:0]              way_hit,
    input  wire [NUM_WAYS-1:0]              way_dirty,
    input  wire [NUM_WAYS*TAG_BITS-1:0]     way_tag,
    input  wire [NUM_WAYS*LINE_BITS-1:0]    way_line,
    input  wire [WAY_BITS-1:0]              victim_way,
    input  wire                             mem_save_done,
    input  wire                             mem_load_done,
    input  wire [LINE_BITS-1:0]             mem_rdata,
    output logic                            busy,
    output logic                            done,
    output logic                            hit,
    output logic [NUM_WAYS-1:0]             way_store,
    output logic [NUM_WAYS-1:0]             way_fill,
    output logic [LINE_BITS-1:0]            fill_line,
    output logic                            touch,
    output logic [WAY_BITS-1:0]             touch_way,
    output logic                            mem_save,
    output logic                            mem_load,
    output logic [ADDR_BITS-1:0]            mem_addr,
    output logic [LINE_BITS-1:0]            mem_wdata
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,     // second lookup after a refill
        SAVE,
        LOAD,
        FILL
    } state_e;

    state_e              state;
    state_e              state_next;
    logic [WAY_BITS-1:0] victim_q;
    logic [WAY_BITS-1:0] hit_way;
    logic [TAG_BITS-1:0] victim_tag;
    logic                lookup;
    logic                any_hit;
    logic                miss;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign any_hit = |way_hit;
    assign lookup  = (state == IDLE && req_valid) || state == LOOKUP;
    assign miss    = lookup && !any_hit;

    assign done = lookup && any_hit;
    assign hit  = done && state == IDLE;        // found on the first try
    assign busy = req_valid || state != IDLE;

    assign way_store = {NUM_WAYS{done && req_write}} & way_hit;
    assign way_fill  = (state == FILL) ? NUM_WAYS'(1) << victim_q : '0;
    assign touch     = done || state == FILL;
    assign touch_way = (state == FILL) ? victim_q : hit_way;

    // write-back goes to the victim's own line address
    assign victim_tag = way_tag[victim_q*TAG_BITS +: TAG_BITS];
    assign mem_save   = state == SAVE;
    assign mem_load   = state == LOAD;
    assign mem_addr   = {mem_save ? victim_tag : req_tag, req_index, OFFSET_BITS'(0)};
    assign mem_wdata  = way_line[victim_q*LINE_BITS +: LINE_BITS];

    always_comb begin
        state_next = state;
        case (state)
            IDLE, LOOKUP: begin
                if (miss) begin
                    state_next = way_dirty[victim_way] ? SAVE : LOAD;
                end else if (state == LOOKUP) begin
                    state_next = IDLE;
                end
            end
            SAVE: begin
                if (mem_save_done) state_next = LOAD;
            end
            LOAD: begin
                if (mem_load_done) state_next = FILL;
            end
            FILL:    state_next = LOOKUP;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            victim_q <= '0;
        end else begin
            state <= state_next;
            if (miss) begin
                victim_q <= victim_way;     // held until the refill is written
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOAD && mem_load_done) begin
            fill_line <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* cache/cache_replace.sv */
// ********************
// cache_replace: one used bit per way and set, picks the victim way
// ********************
`timescale 1ns/1ps
`default_nettype none

module cache_replace
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 64,
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int INDEX_BITS = $clog2(NUM_SETS)
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [INDEX_BITS-1:0]    req_index,
    input  wire                     touch,
    input  wire [WAY_BITS-1:0]      touch_way,
    output logic [WAY_BITS-1:0]     victim_way
);

    logic [NUM_WAYS-1:0] used_q [NUM_SETS];
    logic [NUM_WAYS-1:0] used_set;
    logic [NUM_WAYS-1:0] touch_bit;
    logic [NUM_WAYS-1:0] used_next;

    assign used_set  = used_q[req_index];
    assign touch_bit = NUM_WAYS'(1) << touch_way;

    // a full set restarts with only the way just touched
    always_comb begin
        used_next = used_set | touch_bit;
        if (&used_next) begin
            used_next = touch_bit;
        end
    end

    // lowest way with a clear bit
    always_comb begin
        logic found;
        found      = 1'b0;
        victim_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && !used_set[w]) begin
                victim_way = WAY_BITS'(w);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                used_q[s] <= '0;
            end
        end else if (touch) begin
            used_q[req_index] <= used_next;
        end
    end

endmodule

`default_nettype wire

/* cache/cache_way.sv */
// ********************
// cache_way: tag, valid, dirty and line storage of one way
// ********************
`timescale 1ns/1ps
`default_nettype none

module cache_way
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [INDEX_BITS-1:0]    req_index,
    input  wire [TAG_BITS-1:0]      req_tag,
    input  wire [LINE_BYTES-1:0]    byte_mask,
    input  wire [LINE_BITS-1:0]     line_wdata,
    input  wire                     store,
    input  wire                     fill,
    input  wire [LINE_BITS-1:0]     fill_line,
    output logic                    hit,
    output logic                    dirty,
    output logic [TAG_BITS-1:0]     tag,
    output logic [LINE_BITS-1:0]    line
);

    logic [TAG_BITS-1:0]  tag_mem  [NUM_SETS];
    logic [LINE_BITS-1:0] data_mem [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;
    logic [NUM_SETS-1:0]  dirty_q;
    logic [LINE_BITS-1:0] merged;

    // combinational read of the addressed set
    assign tag   = tag_mem[req_index];
    assign line  = data_mem[req_index];
    assign dirty = dirty_q[req_index];
    assign hit   = valid_q[req_index] && (tag == req_tag);

    // store data merged over the current line
    always_comb begin
        merged = line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (byte_mask[b]) begin
                merged[b*8 +: 8] = line_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[req_index] <= fill_line;
            tag_mem[req_index]  <= req_tag;
        end else if (store) begin
            data_mem[req_index] <= merged;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;          // all lines invalid
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[req_index] <= 1'b1;
            dirty_q[req_index] <= 1'b0;   // fresh copy of memory
        end else if (store) begin
            dirty_q[req_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cache/cache_decode.sv */
// ********************
// cache_decode: latches a cpu request and splits it into tag, index, offset,
// byte mask and line-aligned store data
// ********************
`timescale 1ns/1ps
`default_nettype none

module cache_decode
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [ADDR_BITS-1:0]     addr,
    input  wire [31:0]              wdata,
    input  wire access_size_e       size,
    input  wire                     read_en,
    input  wire                     write_en,
    input  wire                     busy,
    output logic [TAG_BITS-1:0]     req_tag,
    output logic [INDEX_BITS-1:0]   req_index,
    output logic [OFFSET_BITS-1:0]  req_offset,
    output access_size_e            req_size,
    output logic                    req_write,
    output logic                    req_valid,
    output logic [LINE_BYTES-1:0]   byte_mask,
    output logic [LINE_BITS-1:0]    line_wdata
);

    logic                   accept;
    logic [OFFSET_BITS-1:0] offset_in;
    logic [LINE_BYTES-1:0]  mask_in;
    logic [LINE_BITS-1:0]   data_in;

    assign accept    = !busy && (read_en ^ write_en);   // exactly one strobe
    assign offset_in = addr[OFFSET_BITS-1:0];

    always_comb begin
        case (size)
            SIZE_BYTE: mask_in = LINE_BYTES'(1) << offset_in;
            SIZE_HALF: mask_in = LINE_BYTES'(3) << offset_in;
            default:   mask_in = LINE_BYTES'(15) << offset_in;
        endcase
    end

    // bytes above the access width are shifted in too but never masked on
    assign data_in = LINE_BITS'(wdata) << {offset_in, 3'b000};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;    // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag    <= addr[ADDR_BITS-1 -: TAG_BITS];
            req_index  <= addr[OFFSET_BITS +: INDEX_BITS];
            req_offset <= offset_in;
            req_size   <= size;
            req_write  <= write_en;
            byte_mask  <= mask_in;
            line_wdata <= data_in;
        end
    end

endmodule

`default_nettype wire

/* common/cache_pkg.sv */
// ********************
// cache_pkg: line geometry and access size encoding for the data cache
// ********************
`default_nettype none

package cache_pkg;

    localparam int ADDR_BITS   = 32;               // cpu byte address
    localparam int LINE_BYTES  = 16;
    localparam int LINE_BITS   = LINE_BYTES * 8;   // 128
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    // store and load width, encoded as on the cpu side
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2
    } access_size_e;

endpackage

`default_nettype wire
